// File: include/warp_sched_macros.svh
// sizes are fixed at compile time; NUM_WARPS and SJ_STACK_DEPTH must be powers of two
`ifndef WARP_SCHED_MACROS_SVH
`define WARP_SCHED_MACROS_SVH

// warps tracked by the scheduler
`define NUM_WARPS 4

// threads per warp, one mask bit each
`define NUM_THREADS 4

`define PC_WIDTH 32

// local barriers only
`define NUM_BARRIERS 2

// divergence stack entries per warp
`define SJ_STACK_DEPTH 4

`define PEND_CTR_WIDTH 4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the warp scheduler testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module sched_tb \
    -o sched_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sched_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb.f
+incdir+include
verilog/warp_sched_pkg.sv
verilog/warp_state_ctl.sv
verilog/split_join_stack.sv
verilog/issue_buffer.sv
verilog/pending_counter.sv
verilog/sched_top.sv
tests/sched_sva.sv
tests/sched_tb.sv

// File: tests/sched_sva.sv
// bound into sched_top; tracks select fires against release strobes per warp
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_macros.svh"

module sched_sva (
    input wire                            clk,
    input wire                            reset,
    input wire                            issue_valid,
    input wire                            issue_ready,
    input wire warp_sched_pkg::issue_t    issue_data,
    input wire                            sel_valid,
    input wire                            sel_ready,
    input wire warp_sched_pkg::issue_t    sel_data,
    input wire                            decode_unlock,
    input wire warp_sched_pkg::wid_t      decode_wid,
    input wire warp_sched_pkg::branch_t   branch,
    input wire warp_sched_pkg::warp_ctl_t warp_ctl,
    input wire warp_sched_pkg::join_t     join_res
);
    logic [`NUM_WARPS-1:0] held;
    logic [`NUM_WARPS-1:0] fire_w;
    logic [`NUM_WARPS-1:0] release_w;
    logic                  ctl_any;

    assign ctl_any = warp_ctl.wspawn.valid || warp_ctl.tmc.valid || warp_ctl.split.valid
        || warp_ctl.barrier.valid;

    always_comb begin
        for (int i = 0; i < `NUM_WARPS; i++) begin
            fire_w[i] = sel_valid && sel_ready && (sel_data.wid == warp_sched_pkg::wid_t'(i));
            release_w[i] = (decode_unlock && decode_wid == warp_sched_pkg::wid_t'(i))
                || (branch.valid && branch.wid == warp_sched_pkg::wid_t'(i))
                || (ctl_any && warp_ctl.wid == warp_sched_pkg::wid_t'(i))
                || (join_res.valid && join_res.wid == warp_sched_pkg::wid_t'(i));
        end
    end

    // a warp is held from its select fire until decode answers
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= '0;
        end else begin
            held <= fire_w | (held & ~release_w);
        end
    end

    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_data))
        else $error("issue_data changed while stalled by ready");

    a_reset_idle: assert property (@(posedge clk) reset |=> !issue_valid)
        else $error("issue_valid high after reset");

    a_no_double: assert property (@(posedge clk) disable iff (reset) (fire_w & held) == '0)
        else $error("warp selected again without a release");

endmodule

bind sched_top sched_sva u_sva (.*);

`default_nettype wire

// File: tests/sched_tb.sv
// random ready and response timing from seed 37; each test waits on accepted issues
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_macros.svh"

module sched_tb;
    localparam int CLK_NS = 40;
    // roughly 90 issues over all tests, each well under 30 cycles
    localparam int WATCHDOG_NS = 90 * 30 * CLK_NS;
    localparam int NW = `NUM_WARPS;

    logic clk = 1'b0;
    logic reset = 1'b1;
    warp_sched_pkg::pc_t       startup_addr = 32'h0000_1000;
    warp_sched_pkg::warp_ctl_t warp_ctl = '0;
    warp_sched_pkg::branch_t   branch = '0;
    logic                      decode_unlock = 1'b0;
    warp_sched_pkg::wid_t      decode_wid = '0;
    logic                      commit = 1'b0;
    warp_sched_pkg::wid_t      commit_wid = '0;
    logic                      issue_ready = 1'b0;
    logic                      issue_valid;
    warp_sched_pkg::issue_t    issue_data;
    logic                      busy;

    // reference model per warp
    warp_sched_pkg::pc_t    m_pc [NW];
    warp_sched_pkg::tmask_t m_mask [NW];
    bit                     m_active [NW];
    bit                     m_wait [NW];
    bit                     m_held [NW];
    warp_sched_pkg::tmask_t stk_mask [NW][$];
    warp_sched_pkg::pc_t    stk_pc [NW][$];
    bit                     stk_else [NW][$];

    int resp_q[$];
    int commit_q[$];
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;

    sched_top DUT (.*);

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    task automatic flag(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    // random back-pressure, commits and the issue monitor
    always @(posedge clk) begin
        int w;
        issue_ready <= ($urandom % 4) != 0;
        if (!reset && commit_q.size() > 0 && ($urandom % 2) == 1) begin
            commit     <= 1'b1;
            commit_wid <= warp_sched_pkg::wid_t'(commit_q.pop_front());
        end else begin
            commit <= 1'b0;
        end
        if (!reset && issue_valid && issue_ready) begin
            w = int'(issue_data.wid);
            checks++;
            if (!m_active[w]) begin
                flag($sformatf("inactive warp %0d issued", w));
            end else if (m_wait[w]) begin
                flag($sformatf("warp %0d issued while waiting on a barrier", w));
            end else if (m_held[w]) begin
                flag($sformatf("warp %0d issued again before a response", w));
            end else if (issue_data.pc != m_pc[w] || issue_data.tmask != m_mask[w]) begin
                flag($sformatf("warp %0d issued pc %h mask %b, expected pc %h mask %b", w,
                    issue_data.pc, issue_data.tmask, m_pc[w], m_mask[w]));
            end
            m_pc[w]   = m_pc[w] + 32'd4;
            m_held[w] = 1'b1;
            resp_q.push_back(w);
            commit_q.push_back(w);
        end
    end

    // next accepted issue; other warps get a plain unlock
    task automatic take_issue(input int want, output int w);
        forever begin
            @(negedge clk);
            while (resp_q.size() == 0) @(negedge clk);
            repeat ($urandom % 3) @(negedge clk);
            w = resp_q.pop_front();
            m_held[w] = 1'b0;
            if (want < 0 || w == want) return;
            send_unlock(w);
        end
    endtask

    task automatic send_unlock(input int w);
        @(posedge clk);
        decode_unlock <= 1'b1;
        decode_wid    <= warp_sched_pkg::wid_t'(w);
        @(posedge clk);
        decode_unlock <= 1'b0;
    endtask

    task automatic send_ctl(input warp_sched_pkg::warp_ctl_t ctl);
        @(posedge clk);
        warp_ctl <= ctl;
        @(posedge clk);
        warp_ctl <= '0;
    endtask

    task automatic send_branch(input int w, input bit taken, input warp_sched_pkg::pc_t dest);
        @(posedge clk);
        branch <= '{valid: 1'b1, wid: warp_sched_pkg::wid_t'(w), taken: taken, dest: dest};
        if (taken) m_pc[w] = dest;
        @(posedge clk);
        branch <= '0;
    endtask

    task automatic unlock_many(input int n);
        int w;
        repeat (n) begin
            take_issue(-1, w);
            send_unlock(w);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int w;
        int e0;
        int waiting;
        bit arrived [NW];
        warp_sched_pkg::warp_ctl_t ctl;
        void'($urandom(37));
        for (int i = 0; i < NW; i++) begin
            m_active[i] = (i == 0);
            m_pc[i]     = (i == 0) ? startup_addr : '0;
            m_mask[i]   = (i == 0) ? 4'b0001 : 4'b0000;
            m_wait[i]   = 1'b0;
            m_held[i]   = 1'b0;
            arrived[i]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        e0 = errors;
        checks++;
        if (busy !== 1'b1) flag("busy not high after reset");
        unlock_many(6);
        finish_test("reset_and_unlock", e0);

        e0 = errors;
        take_issue(0, w);
        ctl = '0;
        ctl.wspawn = '{valid: 1'b1, wmask: 4'b1110, pc: 32'h0000_2000};
        for (int i = 1; i < NW; i++) begin
            m_active[i] = 1'b1;
            m_mask[i]   = 4'b0001;
            m_pc[i]     = 32'h0000_2000;
        end
        send_ctl(ctl);
        unlock_many(12);
        finish_test("spawn", e0);

        e0 = errors;
        take_issue(3, w);
        ctl = '0;
        ctl.wid = 2'd3;
        ctl.tmc = '{valid: 1'b1, tmask: 4'b0000};
        m_active[3] = 1'b0;
        send_ctl(ctl);
        take_issue(1, w);
        ctl.wid = 2'd1;
        ctl.tmc = '{valid: 1'b1, tmask: 4'b1011};
        m_mask[1] = 4'b1011;
        send_ctl(ctl);
        unlock_many(10);
        finish_test("tmc", e0);

        e0 = errors;
        repeat (10) begin
            take_issue(-1, w);
            send_branch(w, $urandom % 2, {16'h0004, 14'($urandom), 2'b00});
        end
        unlock_many(4);
        finish_test("branch", e0);

        e0 = errors;
        take_issue(1, w);
        ctl = '0;
        ctl.wid = 2'd1;
        ctl.split = '{valid: 1'b1, is_dvg: 1'b1, tmask: 4'b1011, then_tmask: 4'b0011,
            else_tmask: 4'b1000, else_pc: 32'h0000_3000};
        stk_mask[1].push_back(4'b1011);
        stk_pc[1].push_back('0);
        stk_else[1].push_back(1'b0);
        stk_mask[1].push_back(4'b1000);
        stk_pc[1].push_back(32'h0000_3000);
        stk_else[1].push_back(1'b1);
        m_mask[1] = 4'b0011;
        send_ctl(ctl);
        for (int j = 0; j < 2; j++) begin
            take_issue(1, w);
            send_unlock(1);
            take_issue(1, w);
            ctl = '0;
            ctl.wid = 2'd1;
            ctl.sjoin.valid = 1'b1;
            m_mask[1] = stk_mask[1].pop_back();
            if (stk_else[1].pop_back()) begin
                m_pc[1] = stk_pc[1].pop_back();
            end else begin
                void'(stk_pc[1].pop_back());
            end
            send_ctl(ctl);
        end
        unlock_many(6);
        finish_test("split_join", e0);

        // warps 0..2 meet on barrier 1 of size 3
        e0 = errors;
        waiting = 0;
        while (!(arrived[0] && arrived[1] && arrived[2])) begin
            take_issue(-1, w);
            if (arrived[w]) begin
                send_unlock(w);
            end else begin
                arrived[w] = 1'b1;
                ctl = '0;
                ctl.wid = warp_sched_pkg::wid_t'(w);
                ctl.barrier = '{valid: 1'b1, id: 1'b1, size_m1: 2'd2};
                if (waiting == 2) begin
                    for (int i = 0; i < NW; i++) m_wait[i] = 1'b0;
                end else begin
                    m_wait[w] = 1'b1;
                    waiting++;
                end
                send_ctl(ctl);
            end
        end
        while (m_active[0] || m_active[1] || m_active[2] || m_active[3]) begin
            take_issue(-1, w);
            ctl = '0;
            ctl.wid = warp_sched_pkg::wid_t'(w);
            ctl.tmc = '{valid: 1'b1, tmask: 4'b0000};
            m_active[w] = 1'b0;
            send_ctl(ctl);
        end
        @(negedge clk);
        while (commit_q.size() > 0) @(negedge clk);
        repeat (20) begin
            if (busy === 1'b1) @(negedge clk);
        end
        checks++;
        if (busy !== 1'b0) flag("busy still high after all warps ended and committed");
        finish_test("barrier_and_drain", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
            checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/issue_buffer.sv
// two-entry skid buffer; in_ready comes from a flop, so out_ready never reaches the upstream
`timescale 1ns/1ps
`default_nettype none

module issue_buffer (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         in_valid,
    output logic                        in_ready,
    input  wire warp_sched_pkg::issue_t in_data,
    output logic                        out_valid,
    input  wire                         out_ready,
    output warp_sched_pkg::issue_t      out_data
);
    logic                   main_valid;
    logic                   skid_valid;
    warp_sched_pkg::issue_t main_data;
    warp_sched_pkg::issue_t skid_data;
    logic                   main_load;

    // main slot free or draining this cycle
    assign main_load = out_ready || !main_valid;

    assign in_ready  = !skid_valid;
    assign out_valid = main_valid;
    assign out_data  = main_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            main_valid <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && !skid_valid) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (in_valid && !skid_valid && !main_load) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pending_counter.sv
// counters wrap rather than saturate; keep uncommitted issues per warp under 2**PEND_CTR_WIDTH
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_macros.svh"

module pending_counter (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       incr,
    input  wire warp_sched_pkg::wid_t incr_wid,
    input  wire                       decr,
    input  wire warp_sched_pkg::wid_t decr_wid,
    output logic                      all_empty
);
    logic [`PEND_CTR_WIDTH-1:0] pend_ctr [`NUM_WARPS];
    logic [`NUM_WARPS-1:0]      up;
    logic [`NUM_WARPS-1:0]      down;

    always_comb begin
        for (int i = 0; i < `NUM_WARPS; i++) begin
            up[i]   = incr && (incr_wid == warp_sched_pkg::wid_t'(i));
            down[i] = decr && (decr_wid == warp_sched_pkg::wid_t'(i));
        end
    end

    // same-warp incr and decr cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                pend_ctr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                if (up[i] && !down[i]) begin
                    pend_ctr[i] <= pend_ctr[i] + `PEND_CTR_WIDTH'(1);
                end else if (down[i] && !up[i]) begin
                    pend_ctr[i] <= pend_ctr[i] - `PEND_CTR_WIDTH'(1);
                end
            end
        end
    end

    always_comb begin
        all_empty = 1'b1;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            if (pend_ctr[i] != '0) begin
                all_empty = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sched_top.sv
// single branch port, local barriers only; busy comes out of reset high and lags state by one cycle
`timescale 1ns/1ps
`default_nettype none

module sched_top (
    input  wire                            clk,
    input  wire                            reset,
    input  wire warp_sched_pkg::pc_t       startup_addr,
    input  wire warp_sched_pkg::warp_ctl_t warp_ctl,
    input  wire warp_sched_pkg::branch_t   branch,
    input  wire                            decode_unlock,
    input  wire warp_sched_pkg::wid_t      decode_wid,
    input  wire                            commit,
    input  wire warp_sched_pkg::wid_t      commit_wid,
    output logic                           issue_valid,
    output warp_sched_pkg::issue_t         issue_data,
    input  wire                            issue_ready,
    output logic                           busy
);
    logic                   sel_valid;
    logic                   sel_ready;
    warp_sched_pkg::issue_t sel_data;
    warp_sched_pkg::join_t  join_res;
    logic                   issue_fire;
    logic                   any_active;
    logic                   all_empty;

    assign issue_fire = issue_valid && issue_ready;

    warp_state_ctl u_state (
        .clk           (clk),
        .reset         (reset),
        .startup_addr  (startup_addr),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .decode_wid    (decode_wid),
        .join_res      (join_res),
        .issue_fire    (issue_fire),
        .issue_wid     (issue_data.wid),
        .issue_pc      (issue_data.pc),
        .sel_ready     (sel_ready),
        .sel_valid     (sel_valid),
        .sel_data      (sel_data),
        .any_active    (any_active)
    );

    split_join_stack u_sj_stack (
        .clk      (clk),
        .reset    (reset),
        .warp_ctl (warp_ctl),
        .join_res (join_res)
    );

    issue_buffer u_issue_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .in_data   (sel_data),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_data)
    );

    pending_counter u_pending (
        .clk       (clk),
        .reset     (reset),
        .incr      (issue_fire),
        .incr_wid  (issue_data.wid),
        .decr      (commit),
        .decr_wid  (commit_wid),
        .all_empty (all_empty)
    );

    // warp 0 is active out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= any_active || !all_empty;
        end
    end

endmodule

`default_nettype wire

// File: verilog/split_join_stack.sv
// no overflow or underflow check; software must keep nesting within SJ_STACK_DEPTH entries
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_macros.svh"

module split_join_stack (
    input  wire                            clk,
    input  wire                            reset,
    input  wire warp_sched_pkg::warp_ctl_t warp_ctl,
    output warp_sched_pkg::join_t          join_res
);
    localparam int IDXW = $clog2(`SJ_STACK_DEPTH);
    localparam int SPW  = $clog2(`SJ_STACK_DEPTH + 1);

    typedef struct packed {
        logic                   is_dvg;
        logic                   is_else;
        warp_sched_pkg::tmask_t tmask;
        warp_sched_pkg::pc_t    pc;
    } sj_entry_t;

    sj_entry_t       stack_mem [`NUM_WARPS][`SJ_STACK_DEPTH];
    logic [SPW-1:0]  stack_ptr [`NUM_WARPS];
    logic [SPW-1:0]  cur_ptr;
    logic [IDXW-1:0] push_idx;
    logic [IDXW-1:0] top_idx;
    sj_entry_t       top_entry;

    assign cur_ptr   = stack_ptr[warp_ctl.wid];
    assign push_idx  = IDXW'(cur_ptr);
    assign top_idx   = IDXW'(cur_ptr - SPW'(1));
    assign top_entry = stack_mem[warp_ctl.wid][top_idx];

    // divergent split takes two slots
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_WARPS; i++) begin
                stack_ptr[i] <= '0;
            end
        end else if (warp_ctl.split.valid) begin
            stack_ptr[warp_ctl.wid] <= cur_ptr + (warp_ctl.split.is_dvg ? SPW'(2) : SPW'(1));
        end else if (warp_ctl.sjoin.valid) begin
            stack_ptr[warp_ctl.wid] <= cur_ptr - SPW'(1);
        end
    end

    // restore entry below, else entry on top
    always_ff @(posedge clk) begin
        if (warp_ctl.split.valid) begin
            if (warp_ctl.split.is_dvg) begin
                stack_mem[warp_ctl.wid][push_idx] <= '{is_dvg: 1'b1, is_else: 1'b0,
                    tmask: warp_ctl.split.tmask, pc: '0};
                stack_mem[warp_ctl.wid][push_idx + IDXW'(1)] <= '{is_dvg: 1'b1,
                    is_else: 1'b1, tmask: warp_ctl.split.else_tmask,
                    pc: warp_ctl.split.else_pc};
            end else begin
                stack_mem[warp_ctl.wid][push_idx] <= '{is_dvg: 1'b0, is_else: 1'b0,
                    tmask: '0, pc: '0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            join_res <= '0;
        end else begin
            join_res.valid   <= warp_ctl.sjoin.valid;
            join_res.is_dvg  <= top_entry.is_dvg;
            join_res.is_else <= top_entry.is_else;
            join_res.wid     <= warp_ctl.wid;
            join_res.tmask   <= top_entry.tmask;
            join_res.pc      <= top_entry.pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/warp_sched_pkg.sv
// shared types for the warp scheduler; warp-control ops carry no valid of their own beyond each op
`default_nettype none

`include "warp_sched_macros.svh"

package warp_sched_pkg;

    typedef logic [$clog2(`NUM_WARPS)-1:0]    wid_t;
    typedef logic [`NUM_THREADS-1:0]          tmask_t;
    typedef logic [`PC_WIDTH-1:0]             pc_t;
    typedef logic [$clog2(`NUM_BARRIERS)-1:0] bar_id_t;

    // warp-control op fields
    typedef struct packed {
        logic                  valid;
        logic [`NUM_WARPS-1:0] wmask;
        pc_t                   pc;
    } wspawn_t;

    typedef struct packed {
        logic   valid;
        tmask_t tmask;
    } tmc_t;

    typedef struct packed {
        logic   valid;
        logic   is_dvg;
        tmask_t tmask;
        tmask_t then_tmask;
        tmask_t else_tmask;
        pc_t    else_pc;
    } split_t;

    typedef struct packed {
        logic valid;
    } sjoin_t;

    // size_m1 spans one warp index, so sizes go from 1 to NUM_WARPS
    typedef struct packed {
        logic    valid;
        bar_id_t id;
        wid_t    size_m1;
    } barrier_t;

    typedef struct packed {
        wid_t     wid;
        wspawn_t  wspawn;
        tmc_t     tmc;
        split_t   split;
        sjoin_t   sjoin;
        barrier_t barrier;
    } warp_ctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    typedef struct packed {
        logic   valid;
        logic   is_dvg;
        logic   is_else;
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } join_t;

    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } issue_t;

endpackage

`default_nettype wire

// File: verilog/warp_state_ctl.sv
// one warp-control op per cycle is assumed; a warp in a barrier waits until the last member arrives
`timescale 1ns/1ps
`default_nettype none

`include "warp_sched_macros.svh"

module warp_state_ctl (
    input  wire                            clk,
    input  wire                            reset,
    input  wire warp_sched_pkg::pc_t       startup_addr,
    input  wire warp_sched_pkg::warp_ctl_t warp_ctl,
    input  wire warp_sched_pkg::branch_t   branch,
    input  wire                            decode_unlock,
    input  wire warp_sched_pkg::wid_t      decode_wid,
    input  wire warp_sched_pkg::join_t     join_res,
    input  wire                            issue_fire,
    input  wire warp_sched_pkg::wid_t      issue_wid,
    input  wire warp_sched_pkg::pc_t       issue_pc,
    input  wire                            sel_ready,
    output logic                           sel_valid,
    output warp_sched_pkg::issue_t         sel_data,
    output logic                           any_active
);
    localparam int CNTW = $clog2(`NUM_WARPS + 1);

    logic [`NUM_WARPS-1:0]  active_warps, active_warps_n;
    logic [`NUM_WARPS-1:0]  stalled_warps, stalled_warps_n;
    logic [`NUM_WARPS-1:0]  barrier_stalls, barrier_stalls_n;
    logic [`NUM_WARPS-1:0]  barrier_masks [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0]  barrier_masks_n [`NUM_BARRIERS];
    warp_sched_pkg::tmask_t thread_masks [`NUM_WARPS];
    warp_sched_pkg::tmask_t thread_masks_n [`NUM_WARPS];
    warp_sched_pkg::pc_t    warp_pcs [`NUM_WARPS];
    warp_sched_pkg::pc_t    warp_pcs_n [`NUM_WARPS];

    logic [`NUM_WARPS-1:0]  curr_bar_mask;
    logic [CNTW-1:0]        bar_count;
    logic [`NUM_WARPS-1:0]  ready_warps;
    warp_sched_pkg::wid_t   sel_wid;
    logic                   sel_fire;

    assign sel_fire   = sel_valid && sel_ready;
    assign any_active = |active_warps;

    // members already waiting on the addressed barrier
    assign curr_bar_mask = barrier_masks[warp_ctl.barrier.id];

    always_comb begin
        bar_count = '0;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            bar_count = bar_count + CNTW'(curr_bar_mask[i]);
        end
    end

    always_comb begin
        active_warps_n   = active_warps;
        stalled_warps_n  = stalled_warps;
        barrier_stalls_n = barrier_stalls;
        barrier_masks_n  = barrier_masks;
        thread_masks_n   = thread_masks;
        warp_pcs_n       = warp_pcs;

        // spawn
        if (warp_ctl.wspawn.valid) begin
            active_warps_n = active_warps_n | warp_ctl.wspawn.wmask;
            for (int i = 0; i < `NUM_WARPS; i++) begin
                if (warp_ctl.wspawn.wmask[i]) begin
                    thread_masks_n[i] = warp_sched_pkg::tmask_t'(1);
                    warp_pcs_n[i]     = warp_ctl.wspawn.pc;
                end
            end
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        // a zero tmc mask retires the warp
        if (warp_ctl.tmc.valid) begin
            active_warps_n[warp_ctl.wid]  = (warp_ctl.tmc.tmask != '0);
            thread_masks_n[warp_ctl.wid]  = warp_ctl.tmc.tmask;
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        if (warp_ctl.split.valid) begin
            if (warp_ctl.split.is_dvg) begin
                thread_masks_n[warp_ctl.wid] = warp_ctl.split.then_tmask;
            end
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        // join result arrives a cycle after the sjoin strobe
        if (join_res.valid) begin
            if (join_res.is_dvg) begin
                if (join_res.is_else) begin
                    warp_pcs_n[join_res.wid] = join_res.pc;
                end
                thread_masks_n[join_res.wid] = join_res.tmask;
            end
            stalled_warps_n[join_res.wid] = 1'b0;
        end

        // last arrival releases the waiting members
        if (warp_ctl.barrier.valid) begin
            if (bar_count == CNTW'(warp_ctl.barrier.size_m1)) begin
                barrier_masks_n[warp_ctl.barrier.id] = '0;
                barrier_stalls_n = barrier_stalls_n & ~curr_bar_mask;
            end else begin
                barrier_masks_n[warp_ctl.barrier.id][warp_ctl.wid] = 1'b1;
                barrier_stalls_n[warp_ctl.wid] = 1'b1;
            end
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                warp_pcs_n[branch.wid] = branch.dest;
            end
            stalled_warps_n[branch.wid] = 1'b0;
        end

        if (decode_unlock) begin
            stalled_warps_n[decode_wid] = 1'b0;
        end

        // hold the picked warp until decode responds
        if (sel_fire) begin
            stalled_warps_n[sel_wid] = 1'b1;
        end

        if (issue_fire) begin
            warp_pcs_n[issue_wid] = issue_pc + warp_sched_pkg::pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps   <= `NUM_WARPS'(1);
            stalled_warps  <= '0;
            barrier_stalls <= '0;
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                barrier_masks[b] <= '0;
            end
            // warp 0 boots at the startup address
            for (int i = 0; i < `NUM_WARPS; i++) begin
                thread_masks[i] <= (i == 0) ? warp_sched_pkg::tmask_t'(1) : '0;
                warp_pcs[i]     <= (i == 0) ? startup_addr : '0;
            end
        end else begin
            active_warps   <= active_warps_n;
            stalled_warps  <= stalled_warps_n;
            barrier_stalls <= barrier_stalls_n;
            barrier_masks  <= barrier_masks_n;
            thread_masks   <= thread_masks_n;
            warp_pcs       <= warp_pcs_n;
        end
    end

    assign ready_warps = active_warps & ~(stalled_warps | barrier_stalls);

    // lowest index wins
    always_comb begin
        sel_valid = 1'b0;
        sel_wid   = '0;
        for (int i = `NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_valid = 1'b1;
                sel_wid   = warp_sched_pkg::wid_t'(i);
            end
        end
    end

    assign sel_data.wid   = sel_wid;
    assign sel_data.tmask = thread_masks[sel_wid];
    assign sel_data.pc    = warp_pcs[sel_wid];

endmodule

`default_nettype wire
